/* src.f */
common/icache_pkg.sv
logic/icache_ram_way.sv
logic/icache_controller.sv
refill/refill_ar_buffer.sv
refill/refill_line_assembler.sv
logic/icache_top.sv
tests/icache_assert.sv
tests/tb_icache.sv

/* Bender.yml */
package:
  name: icache

sources:
  # RTL in compile order
  - common/icache_pkg.sv
  - logic/icache_ram_way.sv
  - logic/icache_controller.sv
  - refill/refill_ar_buffer.sv
  - refill/refill_line_assembler.sv
  - logic/icache_top.sv

  # Testbench with bound assertions
  - target: test
    files:
      - tests/icache_assert.sv
      - tests/tb_icache.sv

/* tests/tb_icache.sv */
`timescale 1ns/10ps
`default_nettype none

module tb_icache;
   import icache_pkg::*;

   localparam int unsigned TIMEOUT = 200;           // Cycles allowed per wait
   localparam int unsigned SEED    = 32'hcc170b20;

   logic        clk = 1'b0;
   logic        rst_n;
   logic        fetch_req_i;
   addr_t       fetch_addr_i;
   fetch_id_t   fetch_id_i;
   logic        fetch_grant_o;
   fetch_word_t fetch_rdata_o;
   logic        fetch_rvalid_o;
   fetch_id_t   fetch_rid_o;
   addr_t       ar_addr_o;
   logic        ar_valid_o;
   logic        ar_ready_i;
   axi_beat_t   r_data_i;
   logic        r_last_i;
   logic        r_valid_i;
   logic        r_ready_o;
   logic        flush_req_i;
   logic        flush_ack_o;

   logic        stall_on = 1'b0;      // Random idle cycles on AR and R
   int unsigned ar_count = 0;         // Accepted AR transfers
   addr_t       burst_q[$];           // Bursts still owing beats
   int unsigned beat_n = 0;
   int unsigned tb_errors = 0;
   int unsigned tests_run = 0;
   int unsigned tests_failed = 0;
   int unsigned err_mark = 0;

   always #20 clk = ~clk;

   icache_top i_icache_top (.*);

   // --------------------------------------------------------------------------
   // AXI memory model, every beat is its own byte address twice
   // --------------------------------------------------------------------------
   always @(posedge clk)
   begin
      if (rst_n)
      begin
         if (ar_valid_o && ar_ready_i)
         begin
            burst_q.push_back(ar_addr_o);
            ar_count <= ar_count + 1;
         end
         ar_ready_i <= !stall_on || ($urandom % 3 != 0);
         if (r_valid_i && r_ready_o)
         begin
            if (r_last_i)
            begin
               void'(burst_q.pop_front());
               beat_n = 0;
            end
            else
            begin
               beat_n++;
            end
         end
         if (r_valid_i && !r_ready_o)
         begin
            r_valid_i <= 1'b1;                      // Beat holds until taken
         end
         else if (burst_q.size() != 0 && (!stall_on || $urandom % 3 != 0))
         begin
            r_valid_i <= 1'b1;
            r_data_i  <= {2{burst_q[0] + addr_t'(8 * beat_n)}};
            r_last_i  <= (beat_n == 3);
         end
         else
         begin
            r_valid_i <= 1'b0;
         end
      end
   end

   function automatic int unsigned total_errors();
      return tb_errors + i_icache_top.i_icache_assert.fail_count;
   endfunction

   task automatic abort_run(input string what);
      $display("timeout while waiting for %s at t=%0t", what, $time);
      $display("Simulation FAILED");
      $finish;
   endtask

   // A negative exp_ar means the number of refills is not predicted
   task automatic fetch(input addr_t addr, input int exp_ar);
      int unsigned cyc;
      int unsigned ar_mark;
      ar_mark = ar_count;
      fetch_req_i  <= 1'b1;
      fetch_addr_i <= addr;
      fetch_id_i   <= fetch_id_t'($urandom);
      cyc = 0;
      do
      begin
         @(posedge clk);
         cyc++;
      end
      while (!fetch_grant_o && cyc < TIMEOUT);
      if (!fetch_grant_o)
      begin
         abort_run("fetch grant");
      end
      else
      begin
         fetch_req_i <= 1'b0;
         cyc = 0;
         do
         begin
            @(posedge clk);
            cyc++;
         end
         while (!fetch_rvalid_o && cyc < TIMEOUT);
         if (!fetch_rvalid_o)
         begin
            abort_run("fetch response");
         end
         else
         begin
            if (exp_ar >= 0)
            begin
               assert (ar_count - ar_mark == exp_ar)
               else
               begin
                  tb_errors++;
                  $error("error t=%0t ar_valid_o transfers got %0d exp %0d", $time,
                         ar_count - ar_mark, exp_ar);
               end
            end
            if (exp_ar == 0)
            begin
               assert (cyc == 2)
               else
               begin
                  tb_errors++;
                  $error("error t=%0t fetch_rvalid_o latency got %0d exp 2", $time, cyc);
               end
            end
         end
      end
   endtask

   task automatic flush();
      int unsigned cyc;
      flush_req_i <= 1'b1;
      cyc = 0;
      do
      begin
         @(posedge clk);
         cyc++;
      end
      while (!flush_ack_o && cyc < TIMEOUT);
      if (!flush_ack_o)
      begin
         abort_run("flush acknowledge");
      end
      else
      begin
         flush_req_i <= 1'b0;
      end
   endtask

   task automatic end_test(input string name);
      int unsigned n;
      repeat (2) @(posedge clk);                   // Let trailing properties settle
      n = total_errors() - err_mark;
      tests_run++;
      if (n != 0)
         tests_failed++;
      $display("test %0d %s: %s (%0d errors)", tests_run, name, (n == 0) ? "ok" : "bad", n);
      err_mark = total_errors();
   endtask

   // --------------------------------------------------------------------------
   // Test sequence
   // --------------------------------------------------------------------------
   initial
   begin
      addr_t rand_addr;
      void'($urandom(SEED));
      rst_n        <= 1'b0;
      fetch_req_i  <= 1'b0;
      fetch_addr_i <= '0;
      fetch_id_i   <= '0;
      ar_ready_i   <= 1'b0;
      r_data_i     <= '0;
      r_last_i     <= 1'b0;
      r_valid_i    <= 1'b0;
      flush_req_i  <= 1'b0;
      repeat (3) @(posedge clk);
      rst_n <= 1'b1;

      fetch(32'h0000_1040, 1);
      end_test("cold miss");

      fetch(32'h0000_1050, 0);                     // Other word of the same line
      fetch(32'h0000_1044, 0);
      end_test("hit");

      fetch(32'h0000_2000, 1);                     // Three lines of set 0
      fetch(32'h0000_2210, 1);
      fetch(32'h0000_2400, 1);
      fetch(32'h0000_2000, 1);                     // Evicted by the third line
      end_test("set conflict");

      fetch(32'h0000_1040, 0);
      flush();
      fetch(32'h0000_1040, 1);
      fetch(32'h0000_1058, 0);
      end_test("flush");

      stall_on <= 1'b1;
      for (int i = 0; i < 24; i++)
      begin
         if (i == 12)
            flush();
         rand_addr = addr_t'(32'h4000 + $urandom_range(0, 32'h7ff));
         fetch(rand_addr, -1);
         repeat ($urandom % 3) @(posedge clk);
      end
      end_test("random stalls");

      $display("tests %0d, failed %0d, errors %0d", tests_run, tests_failed, total_errors());
      if (total_errors() == 0)
         $display("Simulation PASSED");
      else
         $display("Simulation FAILED");
      $finish;
   end

endmodule

`default_nettype wire

/* tests/icache_assert.sv */
`timescale 1ns/10ps
`default_nettype none

module icache_assert
(
   input logic                    clk,
   input logic                    rst_n,
   input logic                    fetch_req_i,
   input logic                    fetch_grant_i,
   input icache_pkg::addr_t       fetch_addr_i,
   input icache_pkg::fetch_id_t   fetch_id_i,
   input logic                    fetch_rvalid_i,
   input icache_pkg::fetch_word_t fetch_rdata_i,
   input icache_pkg::fetch_id_t   fetch_rid_i,
   input logic                    ar_valid_i,
   input logic                    ar_ready_i,
   input icache_pkg::addr_t       ar_addr_i,
   input logic                    r_valid_i,
   input logic                    r_last_i,
   input logic                    r_ready_i,
   input logic                    flush_ack_i
);
   import icache_pkg::*;

   localparam addr_t LINE_MASK = 32'hffff_ffe0;   // 32-byte lines

   addr_t       addr_q;                           // Open fetch
   fetch_id_t   id_q;
   logic        take;
   int unsigned fail_count = 0;

   // Each beat carries its own byte address twice, the low beat comes first
   function automatic fetch_word_t word_at(input addr_t a);
      addr_t base;
      base = {a[ADDR_W-1:4], 4'h0};
      return {base + 32'd8, base + 32'd8, base, base};
   endfunction

   assign take = fetch_req_i && fetch_grant_i;

   always_ff @(posedge clk or negedge rst_n)
   begin
      if (!rst_n)
      begin
         addr_q <= '0;
         id_q   <= '0;
      end
      else if (take)
      begin
         addr_q <= fetch_addr_i;
         id_q   <= fetch_id_i;
      end
   end

   // --------------------------------------------------------------------------
   // Fetch response
   // --------------------------------------------------------------------------
   rdata_ok: assert property (@(posedge clk) disable iff (!rst_n)
      fetch_rvalid_i |-> fetch_rdata_i == word_at(addr_q))
      else
      begin
         fail_count++;
         $error("error t=%0t fetch_rdata_o got %h exp %h", $time,
                $sampled(fetch_rdata_i), word_at($sampled(addr_q)));
      end

   rid_ok: assert property (@(posedge clk) disable iff (!rst_n)
      fetch_rvalid_i |-> fetch_rid_i == id_q)
      else
      begin
         fail_count++;
         $error("error t=%0t fetch_rid_o got %h exp %h", $time,
                $sampled(fetch_rid_i), $sampled(id_q));
      end

   // --------------------------------------------------------------------------
   // AR and R channels and flush
   // --------------------------------------------------------------------------
   ar_hold: assert property (@(posedge clk) disable iff (!rst_n)
      ar_valid_i && !ar_ready_i |=> ar_valid_i && $stable(ar_addr_i))
      else
      begin
         fail_count++;
         $error("AR valid or address changed before the transfer at t=%0t", $time);
      end

   ar_addr_ok: assert property (@(posedge clk) disable iff (!rst_n)
      ar_valid_i |-> ar_addr_i == (addr_q & LINE_MASK))
      else
      begin
         fail_count++;
         $error("error t=%0t ar_addr_o got %h exp %h", $time,
                $sampled(ar_addr_i), $sampled(addr_q) & LINE_MASK);
      end

   // A finished line holds R off for one cycle while the controller takes it
   r_backpressure: assert property (@(posedge clk) disable iff (!rst_n)
      r_valid_i && r_ready_i && r_last_i |=> !r_ready_i ##1 r_ready_i)
      else
      begin
         fail_count++;
         $error("R ready did not drop for one cycle after the last beat at t=%0t", $time);
      end

   flush_pulse: assert property (@(posedge clk) disable iff (!rst_n)
      flush_ack_i |=> !flush_ack_i)
      else
      begin
         fail_count++;
         $error("flush acknowledge lasted longer than one cycle at t=%0t", $time);
      end

   reset_quiet: assert property (@(posedge clk)
      !rst_n |-> !fetch_rvalid_i && !ar_valid_i && !flush_ack_i && !fetch_grant_i)
      else
      begin
         fail_count++;
         $error("outputs active during reset at t=%0t", $time);
      end

endmodule

bind icache_top icache_assert i_icache_assert
(
   .clk            (clk),
   .rst_n          (rst_n),
   .fetch_req_i    (fetch_req_i),
   .fetch_grant_i  (fetch_grant_o),
   .fetch_addr_i   (fetch_addr_i),
   .fetch_id_i     (fetch_id_i),
   .fetch_rvalid_i (fetch_rvalid_o),
   .fetch_rdata_i  (fetch_rdata_o),
   .fetch_rid_i    (fetch_rid_o),
   .ar_valid_i     (ar_valid_o),
   .ar_ready_i     (ar_ready_i),
   .ar_addr_i      (ar_addr_o),
   .r_valid_i      (r_valid_i),
   .r_last_i       (r_last_i),
   .r_ready_i      (r_ready_o),
   .flush_ack_i    (flush_ack_o)
);

`default_nettype wire

/* logic/icache_top.sv */
`timescale 1ns/10ps
`default_nettype none

module icache_top
#(
   parameter int unsigned NUM_WAYS   = 2,
   parameter int unsigned LINE_WORDS = 2,    // Fetch words per line
   parameter int unsigned NUM_ROWS   = 16,   // Sets
   parameter int unsigned AR_DEPTH   = 2
)
(
   input  logic                    clk,
   input  logic                    rst_n,
   // Fetch port
   input  logic                    fetch_req_i,
   input  icache_pkg::addr_t       fetch_addr_i,
   input  icache_pkg::fetch_id_t   fetch_id_i,
   output logic                    fetch_grant_o,
   output icache_pkg::fetch_word_t fetch_rdata_o,
   output logic                    fetch_rvalid_o,
   output icache_pkg::fetch_id_t   fetch_rid_o,
   // AXI read address channel
   output icache_pkg::addr_t       ar_addr_o,
   output logic                    ar_valid_o,
   input  logic                    ar_ready_i,
   // AXI read data channel
   input  icache_pkg::axi_beat_t   r_data_i,
   input  logic                    r_last_i,
   input  logic                    r_valid_i,
   output logic                    r_ready_o,
   // Flush
   input  logic                    flush_req_i,
   output logic                    flush_ack_o
);
   import icache_pkg::*;

   localparam int unsigned IDX_W = $clog2(NUM_ROWS);
   localparam int unsigned WAY_W = (NUM_WAYS > 1) ? $clog2(NUM_WAYS) : 1;
   localparam int unsigned TAG_W = ADDR_W - OFFSET_W - $clog2(LINE_WORDS) - IDX_W;

   typedef logic [TAG_W:0]               tag_entry_t;   // Valid bit above the tag
   typedef fetch_word_t [LINE_WORDS-1:0] line_t;

   logic [IDX_W-1:0]          ram_addr;
   logic                      ram_write;
   logic [NUM_WAYS-1:0]       tag_req;
   logic [NUM_WAYS-1:0]       data_req;
   tag_entry_t                tag_wdata;
   line_t                     line_wdata;
   tag_entry_t [NUM_WAYS-1:0] tag_rdata;
   line_t      [NUM_WAYS-1:0] data_rdata;
   line_t                     data_rdata_sel;
   logic [WAY_W-1:0]          way_sel;
   logic                      push_valid;
   logic                      push_ready;
   addr_t                     push_addr;
   logic                      line_valid;
   logic                      line_taken;
   line_t                     line;

   // ------------------------------------------------------------------------
   // Tag and data ways, read in parallel
   // ------------------------------------------------------------------------
   for (genvar w = 0; w < NUM_WAYS; w++)
   begin : g_way
      icache_ram_way #(.NUM_ROWS(NUM_ROWS), .entry_t(tag_entry_t)) i_tag_way
      (
         .clk     (clk),
         .rst_n   (rst_n),
         .req_i   (tag_req[w]),
         .write_i (ram_write),
         .addr_i  (ram_addr),
         .wdata_i (tag_wdata),
         .rdata_o (tag_rdata[w])
      );

      icache_ram_way #(.NUM_ROWS(NUM_ROWS), .entry_t(line_t)) i_data_way
      (
         .clk     (clk),
         .rst_n   (rst_n),
         .req_i   (data_req[w]),
         .write_i (ram_write),
         .addr_i  (ram_addr),
         .wdata_i (line_wdata),
         .rdata_o (data_rdata[w])
      );
   end

   assign data_rdata_sel = data_rdata[way_sel];   // Way multiplexer

   icache_controller #(.NUM_WAYS(NUM_WAYS), .LINE_WORDS(LINE_WORDS), .NUM_ROWS(NUM_ROWS))
   i_icache_controller
   (
      .clk            (clk),
      .rst_n          (rst_n),
      .fetch_req_i    (fetch_req_i),
      .fetch_addr_i   (fetch_addr_i),
      .fetch_id_i     (fetch_id_i),
      .fetch_grant_o  (fetch_grant_o),
      .fetch_rdata_o  (fetch_rdata_o),
      .fetch_rvalid_o (fetch_rvalid_o),
      .fetch_rid_o    (fetch_rid_o),
      .ram_addr_o     (ram_addr),
      .ram_write_o    (ram_write),
      .tag_req_o      (tag_req),
      .data_req_o     (data_req),
      .tag_wdata_o    (tag_wdata),
      .line_wdata_o   (line_wdata),
      .tag_rdata_i    (tag_rdata),
      .data_rdata_i   (data_rdata_sel),
      .way_sel_o      (way_sel),
      .ar_valid_o     (push_valid),
      .ar_addr_o      (push_addr),
      .ar_ready_i     (push_ready),
      .line_valid_i   (line_valid),
      .line_i         (line),
      .line_taken_o   (line_taken),
      .flush_req_i    (flush_req_i),
      .flush_ack_o    (flush_ack_o)
   );

   // ------------------------------------------------------------------------
   // Refill path
   // ------------------------------------------------------------------------
   refill_ar_buffer #(.AR_DEPTH(AR_DEPTH)) i_refill_ar_buffer
   (
      .clk         (clk),
      .rst_n       (rst_n),
      .in_valid_i  (push_valid),
      .in_addr_i   (push_addr),
      .in_ready_o  (push_ready),
      .out_valid_o (ar_valid_o),
      .out_addr_o  (ar_addr_o),
      .out_ready_i (ar_ready_i)
   );

   refill_line_assembler #(.LINE_WORDS(LINE_WORDS)) i_refill_line_assembler
   (
      .clk          (clk),
      .rst_n        (rst_n),
      .r_data_i     (r_data_i),
      .r_last_i     (r_last_i),
      .r_valid_i    (r_valid_i),
      .r_ready_o    (r_ready_o),
      .line_valid_o (line_valid),
      .line_o       (line),
      .line_taken_i (line_taken)
   );

endmodule

`default_nettype wire

/* refill/refill_line_assembler.sv */
`timescale 1ns/10ps
`default_nettype none

module refill_line_assembler
#(
   parameter int unsigned LINE_WORDS = 2
)
(
   input  logic                                     clk,
   input  logic                                     rst_n,
   input  icache_pkg::axi_beat_t                    r_data_i,
   input  logic                                     r_last_i,
   input  logic                                     r_valid_i,
   output logic                                     r_ready_o,
   output logic                                     line_valid_o,   // One-cycle pulse
   output icache_pkg::fetch_word_t [LINE_WORDS-1:0] line_o,
   input  logic                                     line_taken_i
);
   import icache_pkg::*;

   localparam int unsigned LINE_W = LINE_WORDS * FETCH_W;
   localparam int unsigned BEATS  = LINE_W / AXI_W;
   localparam int unsigned IDX_W  = (BEATS > 1) ? $clog2(BEATS) : 1;

   logic [LINE_W-1:0] line_q;
   logic [IDX_W-1:0]  beat_idx_q;
   logic              full_q;       // Finished line waits for the controller
   logic              beat_take;
   logic              beat_last;

   assign r_ready_o = !full_q;      // Back-pressure R while a line is held
   assign beat_take = r_valid_i && r_ready_o;
   assign beat_last = r_last_i || (beat_idx_q == IDX_W'(BEATS - 1));
   assign line_o    = line_q;

   // Beats enter at the top, the first one ends at bit 0
   always_ff @(posedge clk)
   begin
      if (beat_take)
      begin
         line_q <= {r_data_i, line_q[LINE_W-1:AXI_W]};
      end
   end

   always_ff @(posedge clk or negedge rst_n)
   begin
      if (!rst_n)
      begin
         beat_idx_q   <= '0;
         full_q       <= 1'b0;
         line_valid_o <= 1'b0;
      end
      else
      begin
         line_valid_o <= beat_take && beat_last;
         if (beat_take)
         begin
            beat_idx_q <= beat_last ? '0 : beat_idx_q + 1'b1;
         end
         if (beat_take && beat_last)
         begin
            full_q <= 1'b1;
         end
         else if (line_taken_i)
         begin
            full_q <= 1'b0;
         end
      end
   end

endmodule

`default_nettype wire

/* refill/refill_ar_buffer.sv */
`timescale 1ns/10ps
`default_nettype none

module refill_ar_buffer
#(
   parameter int unsigned AR_DEPTH = 2
)
(
   input  logic              clk,
   input  logic              rst_n,
   input  logic              in_valid_i,
   input  icache_pkg::addr_t in_addr_i,
   output logic              in_ready_o,
   output logic              out_valid_o,   // Straight to the AR channel
   output icache_pkg::addr_t out_addr_o,
   input  logic              out_ready_i
);
   import icache_pkg::*;

   localparam int unsigned PTR_W = (AR_DEPTH > 1) ? $clog2(AR_DEPTH) : 1;
   localparam int unsigned CNT_W = $clog2(AR_DEPTH + 1);

   addr_t             mem_q [AR_DEPTH];
   logic [PTR_W-1:0]  wr_ptr_q;
   logic [PTR_W-1:0]  rd_ptr_q;
   logic [CNT_W-1:0]  count_q;
   logic              push;
   logic              pop;

   function automatic logic [PTR_W-1:0] ptr_next(input logic [PTR_W-1:0] ptr);
      return (ptr == PTR_W'(AR_DEPTH - 1)) ? '0 : ptr + 1'b1;
   endfunction

   assign in_ready_o  = (count_q != CNT_W'(AR_DEPTH));
   assign out_valid_o = (count_q != '0);
   assign out_addr_o  = mem_q[rd_ptr_q];   // Held until the AR transfer
   assign push        = in_valid_i && in_ready_o;
   assign pop         = out_valid_o && out_ready_i;

   always_ff @(posedge clk)
   begin
      if (push)
      begin
         mem_q[wr_ptr_q] <= in_addr_i;
      end
   end

   // ------------------------------------------------------------------------
   // Pointers and fill level
   // ------------------------------------------------------------------------
   always_ff @(posedge clk or negedge rst_n)
   begin
      if (!rst_n)
      begin
         wr_ptr_q <= '0;
         rd_ptr_q <= '0;
         count_q  <= '0;
      end
      else
      begin
         if (push)
         begin
            wr_ptr_q <= ptr_next(wr_ptr_q);
         end
         if (pop)
         begin
            rd_ptr_q <= ptr_next(rd_ptr_q);
         end
         case ({push, pop})
            2'b10:   count_q <= count_q + 1'b1;
            2'b01:   count_q <= count_q - 1'b1;
            default: count_q <= count_q;
         endcase
      end
   end

endmodule

`default_nettype wire

/* logic/icache_controller.sv */
`timescale 1ns/10ps
`default_nettype none

module icache_controller
#(
   parameter int unsigned NUM_WAYS   = 2,
   parameter int unsigned LINE_WORDS = 2,
   parameter int unsigned NUM_ROWS   = 16,
   localparam int unsigned IDX_W     = $clog2(NUM_ROWS),
   localparam int unsigned WSEL_W    = $clog2(LINE_WORDS),
   localparam int unsigned WAY_W     = (NUM_WAYS > 1) ? $clog2(NUM_WAYS) : 1,
   localparam int unsigned TAG_W     = icache_pkg::ADDR_W - icache_pkg::OFFSET_W
                                       - WSEL_W - IDX_W
)
(
   input  logic                                     clk,
   input  logic                                     rst_n,
   // Fetch port
   input  logic                                     fetch_req_i,
   input  icache_pkg::addr_t                        fetch_addr_i,
   input  icache_pkg::fetch_id_t                    fetch_id_i,
   output logic                                     fetch_grant_o,
   output icache_pkg::fetch_word_t                  fetch_rdata_o,
   output logic                                     fetch_rvalid_o,
   output icache_pkg::fetch_id_t                    fetch_rid_o,
   // Tag and data ways
   output logic [IDX_W-1:0]                         ram_addr_o,
   output logic                                     ram_write_o,
   output logic [NUM_WAYS-1:0]                      tag_req_o,
   output logic [NUM_WAYS-1:0]                      data_req_o,
   output logic [TAG_W:0]                           tag_wdata_o,
   output icache_pkg::fetch_word_t [LINE_WORDS-1:0] line_wdata_o,
   input  logic [NUM_WAYS-1:0][TAG_W:0]             tag_rdata_i,
   input  icache_pkg::fetch_word_t [LINE_WORDS-1:0] data_rdata_i,
   output logic [WAY_W-1:0]                         way_sel_o,
   // Refill path
   output logic                                     ar_valid_o,
   output icache_pkg::addr_t                        ar_addr_o,
   input  logic                                     ar_ready_i,
   input  logic                                     line_valid_i,
   input  icache_pkg::fetch_word_t [LINE_WORDS-1:0] line_i,
   output logic                                     line_taken_o,
   // Flush
   input  logic                                     flush_req_i,
   output logic                                     flush_ack_o
);
   import icache_pkg::*;

   typedef enum logic [2:0] {S_FLUSH, S_IDLE, S_LOOKUP, S_AR, S_WAIT, S_ACK} state_t;

   state_t             state_q;
   state_t             state_d;
   logic [IDX_W-1:0]   row_q;        // Flush walk row
   logic               ack_pend_q;   // Walk was requested, not started by reset
   logic [WAY_W-1:0]   victim_q;     // Round-robin replacement pointer
   logic [TAG_W-1:0]   tag_q;
   logic [IDX_W-1:0]   idx_q;
   logic [WSEL_W-1:0]  word_q;
   fetch_id_t          id_q;
   logic               take;
   logic               hit;
   logic [WAY_W-1:0]   hit_way;
   logic               refill;
   logic               row_last;

   assign fetch_grant_o = (state_q == S_IDLE) && !flush_req_i;
   assign take          = fetch_req_i && fetch_grant_o;
   assign fetch_rid_o   = id_q;
   assign flush_ack_o   = (state_q == S_ACK);
   assign ar_valid_o    = (state_q == S_AR);
   assign ar_addr_o     = {tag_q, idx_q, {(WSEL_W + OFFSET_W){1'b0}}};   // Line aligned
   assign refill        = (state_q == S_WAIT) && line_valid_i;
   assign line_taken_o  = refill;
   assign line_wdata_o  = line_i;
   assign ram_write_o   = (state_q == S_FLUSH) || refill;
   assign tag_wdata_o   = (state_q == S_FLUSH) ? '0 : {1'b1, tag_q};
   assign way_sel_o     = hit_way;
   assign row_last      = (row_q == IDX_W'(NUM_ROWS - 1));

   // Tag compare across all ways
   always_comb
   begin
      hit     = 1'b0;
      hit_way = '0;
      for (int w = 0; w < NUM_WAYS; w++)
      begin
         if (tag_rdata_i[w][TAG_W] && (tag_rdata_i[w][TAG_W-1:0] == tag_q))
         begin
            hit     = 1'b1;
            hit_way = WAY_W'(w);
         end
      end
   end

   // ------------------------------------------------------------------------
   // Next state and RAM control
   // ------------------------------------------------------------------------
   always_comb
   begin
      state_d    = state_q;
      ram_addr_o = idx_q;
      tag_req_o  = '0;
      data_req_o = '0;
      unique case (state_q)
         S_FLUSH:
         begin
            ram_addr_o = row_q;
            tag_req_o  = '1;                                 // Clear the row in every way
            if (row_last)
            begin
               state_d = ack_pend_q ? S_ACK : S_IDLE;
            end
         end
         S_IDLE:
         begin
            ram_addr_o = fetch_addr_i[OFFSET_W + WSEL_W +: IDX_W];
            if (flush_req_i)
            begin
               state_d = S_FLUSH;
            end
            else if (take)
            begin
               tag_req_o  = '1;
               data_req_o = '1;
               state_d    = S_LOOKUP;
            end
         end
         S_LOOKUP: state_d = hit ? S_IDLE : S_AR;
         S_AR:
         begin
            if (ar_ready_i)
            begin
               state_d = S_WAIT;
            end
         end
         S_WAIT:
         begin
            if (line_valid_i)
            begin
               tag_req_o[victim_q]  = 1'b1;                  // Line and tag into the victim
               data_req_o[victim_q] = 1'b1;
               state_d              = S_IDLE;
            end
         end
         S_ACK:    state_d = S_IDLE;
         default:  state_d = S_IDLE;
      endcase
   end

   always_ff @(posedge clk or negedge rst_n)
   begin
      if (!rst_n)
      begin
         state_q        <= S_FLUSH;                          // Reset runs the tag walk
         row_q          <= '0;
         ack_pend_q     <= 1'b0;
         victim_q       <= '0;
         fetch_rvalid_o <= 1'b0;
      end
      else
      begin
         state_q        <= state_d;
         fetch_rvalid_o <= ((state_q == S_LOOKUP) && hit) || refill;
         if (state_q == S_FLUSH)
         begin
            row_q <= row_last ? '0 : row_q + 1'b1;
         end
         if ((state_q == S_IDLE) && flush_req_i)
         begin
            ack_pend_q <= 1'b1;
         end
         else if (state_q == S_ACK)
         begin
            ack_pend_q <= 1'b0;
         end
         if (refill)
         begin
            victim_q <= (victim_q == WAY_W'(NUM_WAYS - 1)) ? '0 : victim_q + 1'b1;
         end
      end
   end

   // Fetch fields and response word
   always_ff @(posedge clk)
   begin
      if (take)
      begin
         tag_q  <= fetch_addr_i[ADDR_W-1 -: TAG_W];
         idx_q  <= fetch_addr_i[OFFSET_W + WSEL_W +: IDX_W];
         word_q <= fetch_addr_i[OFFSET_W +: WSEL_W];
         id_q   <= fetch_id_i;
      end
      if ((state_q == S_LOOKUP) && hit)
      begin
         fetch_rdata_o <= data_rdata_i[word_q];
      end
      else if (refill)
      begin
         fetch_rdata_o <= line_i[word_q];                    // Answer straight from the refill line
      end
   end

endmodule

`default_nettype wire

/* logic/icache_ram_way.sv */
`timescale 1ns/10ps
`default_nettype none

module icache_ram_way
#(
   parameter int unsigned NUM_ROWS = 16,
   parameter type         entry_t  = logic
)
(
   input  logic                        clk,
   input  logic                        rst_n,
   input  logic                        req_i,
   input  logic                        write_i,
   input  logic [$clog2(NUM_ROWS)-1:0] addr_i,   // Row index
   input  entry_t                      wdata_i,
   output entry_t                      rdata_o
);

   entry_t mem_q [NUM_ROWS];

   // Write port
   always_ff @(posedge clk)
   begin
      if (req_i && write_i)
      begin
         mem_q[addr_i] <= wdata_i;
      end
   end

   // Read data appears one cycle after the request and holds until the next read
   always_ff @(posedge clk or negedge rst_n)
   begin
      if (!rst_n)
      begin
         rdata_o <= '0;
      end
      else if (req_i && !write_i)
      begin
         rdata_o <= mem_q[addr_i];
      end
   end

endmodule

`default_nettype wire

/* common/icache_pkg.sv */
`default_nettype none

package icache_pkg;

   // -------------------------------------------------------------------------
   // Fixed widths of the fetch port and the AXI read path
   // -------------------------------------------------------------------------
   localparam int unsigned ADDR_W   = 32;                  // Byte address
   localparam int unsigned FETCH_W  = 128;                 // One fetch word
   localparam int unsigned ID_W     = 16;                  // Fetch transaction ID
   localparam int unsigned AXI_W    = 64;                  // One read beat

   // Byte offset inside one fetch word
   localparam int unsigned OFFSET_W = $clog2(FETCH_W / 8);

   // -------------------------------------------------------------------------
   // Payload types
   // -------------------------------------------------------------------------
   typedef logic [ADDR_W-1:0]  addr_t;
   typedef logic [FETCH_W-1:0] fetch_word_t;
   typedef logic [ID_W-1:0]    fetch_id_t;
   typedef logic [AXI_W-1:0]   axi_beat_t;

endpackage

`default_nettype wire
